//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        load   = 7'b0000011
    } opcode_e;

    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_sll     = 3'b001;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_srl_sra = 3'b101;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;
    localparam logic [2:0] funct3_lw      = 3'b010;

    localparam logic [6:0] funct7_base = 7'b0000000;
    // selects sub and sra
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    // r-type field view and generic instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

endpackage

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // both memories are word addressed
    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;

    typedef logic [$clog2(imem_depth)-1:0] mem_addr_t;

    typedef enum logic [3:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra,
        slt
    } alu_op_e;

    typedef enum logic {
        imm_i,
        imm_u
    } imm_kind_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        imm_kind_e imm_kind;
        // lui adds its immediate to zero
        logic      zero_a;
        logic      mem_to_reg;
        logic      reg_write;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } ctrl_t;

    typedef struct packed {
        logic      we;
        mem_addr_t addr;
        word_t     data;
    } mem_load_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

`default_nettype wire

//--- source/decoder.sv
`default_nettype none

module decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  instr_t instr,
    output ctrl_t  ctrl,
    output logic   illegal
);

    // alt funct7 only on add/sub and the right shifts
    logic funct7_ok;

    assign funct7_ok = (instr.funct7 == funct7_base) ||
                       ((instr.funct7 == funct7_alt) &&
                        (instr.funct3 == funct3_add_sub || instr.funct3 == funct3_srl_sra));

    always_comb begin
        alu_op_e right_op;

        right_op      = (instr.funct7 == funct7_alt) ? sra : srl;
        ctrl          = '0;
        ctrl.alu_op   = add;
        ctrl.imm_kind = imm_i;
        ctrl.rd       = instr.rd;
        ctrl.rs1      = instr.rs1;
        ctrl.rs2      = instr.rs2;
        illegal       = 1'b0;

        case (instr.opcode)
            op: begin
                ctrl.reg_write = 1'b1;
                case (instr.funct3)
                    funct3_add_sub: begin
                        if (instr.funct7 == funct7_alt) begin
                            ctrl.alu_op = sub;
                        end
                    end
                    funct3_sll:     ctrl.alu_op = sll;
                    funct3_slt:     ctrl.alu_op = slt;
                    funct3_xor:     ctrl.alu_op = xor_op;
                    funct3_srl_sra: ctrl.alu_op = right_op;
                    funct3_or:      ctrl.alu_op = or_op;
                    funct3_and:     ctrl.alu_op = and_op;
                    default: begin
                        // sltu
                        ctrl.reg_write = 1'b0;
                        illegal        = 1'b1;
                    end
                endcase
                if (!funct7_ok) begin
                    ctrl.reg_write = 1'b0;
                    illegal        = 1'b1;
                end
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                case (instr.funct3)
                    funct3_add_sub: ctrl.alu_op = add;
                    funct3_xor:     ctrl.alu_op = xor_op;
                    funct3_or:      ctrl.alu_op = or_op;
                    funct3_and:     ctrl.alu_op = and_op;
                    funct3_sll:     ctrl.alu_op = sll;
                    funct3_srl_sra: ctrl.alu_op = right_op;
                    default: begin
                        // slti and sltiu
                        ctrl.reg_write = 1'b0;
                        illegal        = 1'b1;
                    end
                endcase
                // funct7 is only an encoding field for the shifts
                if ((instr.funct3 == funct3_sll || instr.funct3 == funct3_srl_sra) &&
                    !funct7_ok) begin
                    ctrl.reg_write = 1'b0;
                    illegal        = 1'b1;
                end
            end
            lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm_kind  = imm_u;
                ctrl.zero_a    = 1'b1;
            end
            load: begin
                if (instr.funct3 == funct3_lw) begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.use_imm    = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
    end

    a_illegal_never_writes: assert final (!(illegal && ctrl.reg_write));

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

module fetch_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  mem_load_t imem_load,
    output word_t     pc,
    output instr_t    instr
);

    instr_t    imem [imem_depth];
    mem_addr_t fetch_addr;

    // pc parks at 0 until run rises
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    // program load only while the core is held
    always_ff @(posedge clk) begin
        if (imem_load.we && !run) begin
            imem[imem_load.addr] <= imem_load.data;
        end
    end

    // word index that wraps past the end of the array
    assign fetch_addr = pc[$bits(mem_addr_t)+1:2];
    assign instr      = imem[fetch_addr];

    a_no_load_while_running: assert property (
        @(posedge clk) disable iff (reset)
        !(imem_load.we && run)
    );

endmodule

`default_nettype wire

//--- source/register_file.sv
`default_nettype none

module register_file
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      we,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [2**$bits(reg_addr_t)];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**$bits(reg_addr_t); i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // old value on a same-cycle read of rd
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    a_x0_stays_zero: assert property (
        @(posedge clk) disable iff (reset)
        regs[0] == '0
    );

endmodule

`default_nettype wire

//--- source/imm_gen.sv
`default_nettype none

module imm_gen
    import isa_pkg::*;
    import core_pkg::*;
(
    input  instr_t    instr,
    input  imm_kind_e kind,
    output word_t     imm
);

    instr_i_t i_view;
    instr_u_t u_view;

    assign i_view = instr_i_t'(instr);
    assign u_view = instr_u_t'(instr);

    always_comb begin
        case (kind)
            // upper 20 bits above 12 zero bits
            imm_u:   imm = {u_view.imm, 12'b0};
            default: imm = {{(xlen-12){i_view.imm[11]}}, i_view.imm};
        endcase
    end

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu
    import core_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    logic [$clog2(xlen)-1:0] shamt;

    // only the low bits of b shift
    assign shamt = b[$clog2(xlen)-1:0];

    always_comb begin
        case (op)
            add:     result = a + b;
            sub:     result = a - b;
            and_op:  result = a & b;
            or_op:   result = a | b;
            xor_op:  result = a ^ b;
            sll:     result = a << shamt;
            srl:     result = a >> shamt;
            sra:     result = word_t'($signed(a) >>> shamt);
            slt:     result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/data_memory.sv
`default_nettype none

module data_memory
    import core_pkg::*;
(
    input  logic      clk,
    input  mem_load_t dmem_load,
    input  mem_addr_t addr,
    output word_t     rdata
);

    word_t mem [dmem_depth];

    always_ff @(posedge clk) begin
        if (dmem_load.we) begin
            mem[dmem_load.addr] <= dmem_load.data;
        end
    end

    // asynchronous read for lw
    assign rdata = mem[addr];

    a_load_addr_known: assert property (
        @(posedge clk)
        dmem_load.we |-> !$isunknown(dmem_load.addr)
    );

endmodule

`default_nettype wire

//--- source/cpu.sv
`default_nettype none

module cpu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  mem_load_t imem_load,
    input  mem_load_t dmem_load,
    output retire_t   retire,
    output logic      illegal
);

    word_t     pc;
    instr_t    instr;
    ctrl_t     ctrl;
    logic      dec_illegal;
    logic      reg_we;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    word_t     load_data;
    word_t     wb_data;
    mem_load_t dmem_load_held;

    fetch_unit fetch_unit0 (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .imem_load (imem_load),
        .pc        (pc),
        .instr     (instr)
    );

    decoder decoder0 (
        .instr   (instr),
        .ctrl    (ctrl),
        .illegal (dec_illegal)
    );

    register_file register_file0 (
        .clk    (clk),
        .reset  (reset),
        .we     (reg_we),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rd     (ctrl.rd),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    imm_gen imm_gen0 (
        .instr (instr),
        .kind  (ctrl.imm_kind),
        .imm   (imm)
    );

    assign alu_a = ctrl.zero_a ? '0 : rs1_data;
    assign alu_b = ctrl.use_imm ? imm : rs2_data;

    alu alu0 (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    // data loads are dropped once the core runs
    always_comb begin
        dmem_load_held    = dmem_load;
        dmem_load_held.we = dmem_load.we && !run;
    end

    data_memory data_memory0 (
        .clk       (clk),
        .dmem_load (dmem_load_held),
        .addr      (alu_result[$bits(mem_addr_t)+1:2]),
        .rdata     (load_data)
    );

    assign wb_data = ctrl.mem_to_reg ? load_data : alu_result;
    assign reg_we  = run && ctrl.reg_write;
    assign illegal = run && dec_illegal;

    // writes to x0 are not reported
    assign retire.valid = reg_we && (ctrl.rd != '0);
    assign retire.pc    = pc;
    assign retire.rd    = ctrl.rd;
    assign retire.data  = wb_data;

endmodule

`default_nettype wire

//--- include/rv_encode.svh
`ifndef RV_ENCODE_SVH
`define RV_ENCODE_SVH

// expects isa_pkg imported by the including module

function automatic instr_t enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                 input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [4:0] rs2);
    instr_t w;
    w.funct7 = funct7;
    w.rs2    = rs2;
    w.rs1    = rs1;
    w.funct3 = funct3;
    w.rd     = rd;
    w.opcode = op;
    return w;
endfunction

function automatic instr_t enc_i(input opcode_e opc, input logic [2:0] funct3,
                                 input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [11:0] imm);
    instr_i_t w;
    w.imm    = imm;
    w.rs1    = rs1;
    w.funct3 = funct3;
    w.rd     = rd;
    w.opcode = opc;
    return instr_t'(w);
endfunction

// slli, srli, srai
function automatic instr_t enc_shift(input logic [6:0] funct7, input logic [2:0] funct3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] shamt);
    instr_t w;
    w        = enc_r(funct7, funct3, rd, rs1, shamt);
    w.opcode = op_imm;
    return w;
endfunction

function automatic instr_t enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    instr_u_t w;
    w.imm    = imm;
    w.rd     = rd;
    w.opcode = lui;
    return instr_t'(w);
endfunction

function automatic instr_t enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                  input logic [11:0] imm);
    return enc_i(load, funct3_lw, rd, rs1, imm);
endfunction

// store opcode that the core rejects
function automatic instr_t enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                  input logic [11:0] imm);
    return instr_t'({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011});
endfunction

`endif

//--- dv/tb_cpu.sv
`default_nettype none

module tb_cpu
    import isa_pkg::*;
    import core_pkg::*;
();

    `include "rv_encode.svh"

    logic      clk;
    logic      reset;
    logic      run;
    mem_load_t imem_load;
    mem_load_t dmem_load;
    retire_t   retire;
    logic      illegal;

    int        seed;
    string     test_name;
    int        errors;
    int        test_errors;
    int        tests_run;
    int        tests_failed;
    int        prog_len;
    int        n_expected;
    int        retire_count;
    int        cyc;

    // expected behavior per program slot
    instr_t    prog [imem_depth];
    logic      exp_valid [imem_depth];
    logic      exp_illegal [imem_depth];
    reg_addr_t exp_rd [imem_depth];
    word_t     exp_data [imem_depth];
    word_t     reg_model [32];
    word_t     dmem_model [dmem_depth];

    cpu dut0 (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .imem_load (imem_load),
        .dmem_load (dmem_load),
        .retire    (retire),
        .illegal   (illegal)
    );

    always #2 clk = ~clk;

    // cycle index since run rose and retires seen in this test
    always @(posedge clk) begin
        cyc <= run ? cyc + 1 : 0;
        if (reset) begin
            retire_count <= 0;
        end else if (run && retire.valid) begin
            retire_count <= retire_count + 1;
        end
    end

    task automatic value_error(input string what, input word_t expected, input word_t actual);
        $display("Error %s: %s expected %h actual %h", test_name, what, expected, actual);
        errors++;
        test_errors++;
    endtask

    a_valid: assert property (@(posedge clk) disable iff (reset || !run)
        retire.valid == exp_valid[cyc])
        else value_error("retire.valid", word_t'($sampled(exp_valid[cyc])),
                         word_t'($sampled(retire.valid)));

    a_illegal: assert property (@(posedge clk) disable iff (reset || !run)
        illegal == exp_illegal[cyc])
        else value_error("illegal", word_t'($sampled(exp_illegal[cyc])),
                         word_t'($sampled(illegal)));

    a_pc: assert property (@(posedge clk) disable iff (reset || !run)
        retire.valid |-> retire.pc == word_t'(cyc * 4))
        else value_error("retire.pc", word_t'($sampled(cyc) * 4), $sampled(retire.pc));

    a_rd: assert property (@(posedge clk) disable iff (reset || !run)
        retire.valid |-> retire.rd == exp_rd[cyc])
        else value_error("retire.rd", word_t'($sampled(exp_rd[cyc])),
                         word_t'($sampled(retire.rd)));

    a_data: assert property (@(posedge clk) disable iff (reset || !run)
        retire.valid |-> retire.data == exp_data[cyc])
        else value_error("retire.data", $sampled(exp_data[cyc]), $sampled(retire.data));

    task automatic end_simulation(input bit ok);
        if (ok) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    function automatic word_t expected_alu(input logic [2:0] f3, input logic alt,
                                           input word_t a, input word_t b);
        case (f3)
            funct3_add_sub: return alt ? a - b : a + b;
            funct3_sll:     return a << b[4:0];
            funct3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            funct3_xor:     return a ^ b;
            funct3_srl_sra: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            funct3_or:      return a | b;
            default:        return a & b;
        endcase
    endfunction

    // reference behavior of one instruction on the register model
    function automatic void predict(input instr_t w, output logic legal, output word_t value);
        word_t a;
        word_t imm;
        word_t ea;
        logic  alt;
        a     = reg_model[w.rs1];
        imm   = {{20{w.funct7[6]}}, w.funct7, w.rs2};
        ea    = a + imm;
        alt   = (w.funct3 == funct3_srl_sra) && (w.funct7 == funct7_alt);
        legal = 1'b1;
        value = '0;
        case (w.opcode)
            op:      value = expected_alu(w.funct3, w.funct7 == funct7_alt, a, reg_model[w.rs2]);
            op_imm:  value = expected_alu(w.funct3, alt, a, imm);
            lui:     value = {w.funct7, w.rs2, w.rs1, w.funct3, 12'h000};
            load:    value = dmem_model[ea[7:2]];
            default: legal = 1'b0;
        endcase
    endfunction

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        prog_len    = 0;
        n_expected  = 0;
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
        for (int i = 0; i < dmem_depth; i++) begin
            dmem_model[i] = {16'hda7a, 10'b0, 6'(i)};
        end
    endtask

    task automatic emit(input instr_t w);
        logic  legal;
        word_t value;
        predict(w, legal, value);
        prog[prog_len]        = w;
        exp_valid[prog_len]   = legal && (w.rd != 5'd0);
        exp_illegal[prog_len] = !legal;
        exp_rd[prog_len]      = w.rd;
        exp_data[prog_len]    = value;
        if (legal && w.rd != 5'd0) begin
            reg_model[w.rd] = value;
            n_expected++;
        end
        prog_len++;
    endtask

    task automatic emit_random_alu();
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        kind = {$random(seed)} % 17;
        rd   = reg_addr_t'(1 + {$random(seed)} % 31);
        rs1  = reg_addr_t'($random(seed));
        rs2  = reg_addr_t'($random(seed));
        imm  = 12'($random(seed));
        case (kind)
            0:       emit(enc_r(funct7_base, funct3_add_sub, rd, rs1, rs2));
            1:       emit(enc_r(funct7_alt, funct3_add_sub, rd, rs1, rs2));
            2:       emit(enc_r(funct7_base, funct3_sll, rd, rs1, rs2));
            3:       emit(enc_r(funct7_base, funct3_slt, rd, rs1, rs2));
            4:       emit(enc_r(funct7_base, funct3_xor, rd, rs1, rs2));
            5:       emit(enc_r(funct7_base, funct3_srl_sra, rd, rs1, rs2));
            6:       emit(enc_r(funct7_alt, funct3_srl_sra, rd, rs1, rs2));
            7:       emit(enc_r(funct7_base, funct3_or, rd, rs1, rs2));
            8:       emit(enc_r(funct7_base, funct3_and, rd, rs1, rs2));
            9:       emit(enc_i(op_imm, funct3_add_sub, rd, rs1, imm));
            10:      emit(enc_i(op_imm, funct3_xor, rd, rs1, imm));
            11:      emit(enc_i(op_imm, funct3_or, rd, rs1, imm));
            12:      emit(enc_i(op_imm, funct3_and, rd, rs1, imm));
            13:      emit(enc_shift(funct7_base, funct3_sll, rd, rs1, imm[4:0]));
            14:      emit(enc_shift(funct7_base, funct3_srl_sra, rd, rs1, imm[4:0]));
            15:      emit(enc_shift(funct7_alt, funct3_srl_sra, rd, rs1, imm[4:0]));
            default: emit(enc_lui(rd, {imm, imm[7:0]}));
        endcase
    endtask

    // unused slots hold addi x0, x0, index
    task automatic load_memories();
        for (int i = 0; i < imem_depth; i++) begin
            imem_load.we   = 1'b1;
            imem_load.addr = mem_addr_t'(i);
            imem_load.data = (i < prog_len) ? prog[i] :
                             enc_i(op_imm, funct3_add_sub, 5'd0, 5'd0, 12'(i));
            dmem_load.we   = 1'b1;
            dmem_load.addr = mem_addr_t'(i);
            dmem_load.data = dmem_model[i];
            @(negedge clk);
        end
        imem_load.we = 1'b0;
        dmem_load.we = 1'b0;
    endtask

    task automatic run_program();
        int waited;
        run = 1'b0;
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        load_memories();
        run    = 1'b1;
        waited = 0;
        while (retire_count < n_expected && waited <= prog_len + 8) begin
            @(negedge clk);
            waited++;
        end
        run = 1'b0;
        if (retire_count < n_expected) begin
            $display("timeout in test %s: only %0d of %0d retires seen",
                     test_name, retire_count, n_expected);
            errors++;
            test_errors++;
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d retires, %0d errors", test_name, retire_count, test_errors);
    endtask

    initial begin
        logic [4:0] shamt;
        seed         = 32'hbc2d;
        clk          = 1'b0;
        reset        = 1'b1;
        run          = 1'b0;
        imem_load    = '0;
        dmem_load    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        begin_test("r_type");
        emit(enc_lui(5'd1, 20'($random(seed))));
        emit(enc_i(op_imm, funct3_add_sub, 5'd1, 5'd1, 12'($random(seed))));
        emit(enc_lui(5'd2, 20'($random(seed))));
        emit(enc_i(op_imm, funct3_add_sub, 5'd2, 5'd2, 12'($random(seed))));
        emit(enc_r(funct7_base, funct3_add_sub, 5'd3, 5'd1, 5'd2));
        emit(enc_r(funct7_alt, funct3_add_sub, 5'd4, 5'd1, 5'd2));
        emit(enc_r(funct7_base, funct3_and, 5'd5, 5'd1, 5'd2));
        emit(enc_r(funct7_base, funct3_or, 5'd6, 5'd1, 5'd2));
        emit(enc_r(funct7_base, funct3_xor, 5'd7, 5'd1, 5'd2));
        emit(enc_r(funct7_base, funct3_sll, 5'd8, 5'd1, 5'd2));
        emit(enc_r(funct7_base, funct3_srl_sra, 5'd9, 5'd1, 5'd2));
        emit(enc_r(funct7_alt, funct3_srl_sra, 5'd10, 5'd1, 5'd2));
        emit(enc_r(funct7_base, funct3_slt, 5'd11, 5'd1, 5'd2));
        emit(enc_r(funct7_base, funct3_slt, 5'd12, 5'd2, 5'd1));
        run_program();

        // negative source and negative immediates
        begin_test("i_type");
        shamt = 5'd1 + 5'({$random(seed)} % 31);
        emit(enc_lui(5'd1, 20'hc0000 | 20'($random(seed))));
        emit(enc_i(op_imm, funct3_add_sub, 5'd1, 5'd1, 12'($random(seed))));
        emit(enc_i(op_imm, funct3_xor, 5'd2, 5'd1, 12'h800 | 12'($random(seed))));
        emit(enc_i(op_imm, funct3_or, 5'd3, 5'd1, 12'h800 | 12'($random(seed))));
        emit(enc_i(op_imm, funct3_and, 5'd4, 5'd1, 12'h800 | 12'($random(seed))));
        emit(enc_shift(funct7_base, funct3_sll, 5'd5, 5'd1, shamt));
        emit(enc_shift(funct7_base, funct3_srl_sra, 5'd6, 5'd1, shamt));
        emit(enc_shift(funct7_alt, funct3_srl_sra, 5'd7, 5'd1, shamt));
        run_program();

        begin_test("lui_lw");
        dmem_model[2] = 32'd1234;
        emit(enc_i(op_imm, funct3_add_sub, 5'd6, 5'd0, 12'd4));
        emit(enc_lw(5'd8, 5'd6, 12'd4));
        emit(enc_lui(5'd9, 20'($random(seed))));
        emit(enc_lw(5'd10, 5'd0, 12'd12));
        run_program();

        begin_test("x0");
        emit(enc_i(op_imm, funct3_add_sub, 5'd0, 5'd0, 12'd5));
        emit(enc_lui(5'd0, 20'($random(seed))));
        emit(enc_i(op_imm, funct3_add_sub, 5'd1, 5'd0, 12'($random(seed))));
        emit(enc_r(funct7_base, funct3_add_sub, 5'd0, 5'd1, 5'd1));
        emit(enc_r(funct7_base, funct3_add_sub, 5'd2, 5'd0, 5'd1));
        emit(enc_r(funct7_base, funct3_add_sub, 5'd3, 5'd1, 5'd0));
        run_program();

        begin_test("pc");
        for (int i = 1; i < 5; i++) begin
            emit(enc_lui(5'(i), 20'($random(seed))));
        end
        repeat (40) emit_random_alu();
        run_program();

        // sw sits at pc 8
        begin_test("illegal");
        emit(enc_i(op_imm, funct3_add_sub, 5'd1, 5'd0, 12'd7));
        emit(enc_i(op_imm, funct3_add_sub, 5'd2, 5'd0, 12'd9));
        emit(enc_sw(5'd2, 5'd1, 12'd0));
        emit(enc_r(funct7_base, funct3_add_sub, 5'd3, 5'd1, 5'd2));
        emit(enc_i(op_imm, funct3_add_sub, 5'd4, 5'd3, 12'd1));
        run_program();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        end_simulation(errors == 0 && tests_failed == 0);
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
source/isa_pkg.sv
source/core_pkg.sv
source/decoder.sv
source/fetch_unit.sv
source/register_file.sv
source/imm_gen.sv
source/alu.sv
source/data_memory.sv
source/cpu.sv
dv/tb_cpu.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - files:
      - source/isa_pkg.sv
      - source/core_pkg.sv
      - source/decoder.sv
      - source/fetch_unit.sv
      - source/register_file.sv
      - source/imm_gen.sv
      - source/alu.sv
      - source/data_memory.sv
      - source/cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_cpu.sv
